//--- hw/axil_pkg.sv
package axil_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int AXIL_ADDR_MAX_W = 32;    // widest address carried on AW/AR.
    localparam int AXIL_DATA_W     = 32;
    localparam int AXIL_STRB_W     = AXIL_DATA_W / 8;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // response and protection
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axil_resp_t;                          // bit 1 set means error.

    localparam logic [2:0] AXIL_PROT_DEFAULT = 3'b000;  // unprivileged, secure, data.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // channel payloads
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // address beat, shared by AW and AR.
    // narrower buses use the low bits only.
    typedef logic [AXIL_ADDR_MAX_W-1:0] axil_aw_t;

    typedef struct packed {
        logic [AXIL_DATA_W-1:0] data;
        logic [AXIL_STRB_W-1:0] strb;       // one bit per data byte.
    } axil_w_t;

endpackage

//--- hw/host_cmd_pkg.sv
package host_cmd_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host command port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic {
        CMD_READ  = 1'b0,
        CMD_WRITE = 1'b1
    } cmd_kind_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // word returned by register 0, ascii "AXL1".
    localparam logic [31:0] REG_ID_VALUE = 32'h41584c31;

    localparam int REG_ID_INDEX = 0;        // read-only slot.

endpackage

//--- hw/axil_chan_reg.sv
`timescale 1ns/1ps

// one beat of an outgoing AXI-Lite channel, held until the slave takes it
module axil_chan_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,

    input  logic     load_valid,
    input  payload_t load_data,
    output logic     empty,

    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    logic     full;
    payload_t beat;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (!full && load_valid) begin
            full <= 1'b1;                   // accepted only when empty.
        end else if (full && out_ready) begin
            full <= 1'b0;                   // receiver took the beat.
        end
    end

    always_ff @(posedge clk) begin
        if (!full && load_valid) begin
            beat <= load_data;
        end
    end

    assign empty     = ~full;
    assign out_valid = full;
    assign out_data  = beat;                // stable while valid is high.

endmodule

//--- hw/axil_master_ctrl.sv
`timescale 1ns/1ps

module axil_master_ctrl import axil_pkg::*, host_cmd_pkg::*; #(
    parameter int ADDR_W = 12
) (
    input  logic                   clk,
    input  logic                   rst,

    // host command port
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    input  cmd_kind_t              cmd_kind,
    input  logic [ADDR_W-1:0]      cmd_addr,
    input  logic [AXIL_DATA_W-1:0] cmd_wdata,
    input  logic [AXIL_STRB_W-1:0] cmd_wstrb,

    // host response port
    output logic                   rsp_valid,
    input  logic                   rsp_ready,
    output logic [AXIL_DATA_W-1:0] rsp_rdata,
    output logic                   rsp_err,

    // channel register load sides
    output logic                   aw_load,
    output axil_aw_t               aw_load_data,
    input  logic                   aw_empty,
    output logic                   w_load,
    output axil_w_t                w_load_data,
    input  logic                   w_empty,
    output logic                   ar_load,
    output axil_aw_t               ar_load_data,
    input  logic                   ar_empty,

    // response channels
    input  logic                   bvalid,
    input  axil_resp_t             bresp,
    output logic                   bready,
    input  logic                   rvalid,
    input  axil_resp_t             rresp,
    input  logic [AXIL_DATA_W-1:0] rdata,
    output logic                   rready
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND,
        ST_RESP,
        ST_HOLD
    } ctrl_state_t;

    ctrl_state_t state;
    ctrl_state_t state_next;

    logic cmd_take;
    logic is_write;
    logic sent;
    logic b_take;
    logic r_take;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // command side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign cmd_take = cmd_valid && cmd_ready;

    // AW and W go out in the same cycle.
    assign aw_load      = cmd_take && (cmd_kind == CMD_WRITE);
    assign w_load       = cmd_take && (cmd_kind == CMD_WRITE);
    assign ar_load      = cmd_take && (cmd_kind == CMD_READ);
    assign aw_load_data = axil_aw_t'(cmd_addr);
    assign ar_load_data = axil_aw_t'(cmd_addr);
    assign w_load_data  = '{data: cmd_wdata, strb: cmd_wstrb};

    always_ff @(posedge clk) begin
        if (cmd_take) begin
            is_write <= (cmd_kind == CMD_WRITE);
        end
    end

    // both AW and W must be gone before B is awaited.
    assign sent = is_write ? (aw_empty && w_empty) : ar_empty;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // state machine
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign bready = (state == ST_RESP) && is_write;
    assign rready = (state == ST_RESP) && !is_write;
    assign b_take = bvalid && bready;       // wait on bvalid, not on bresp alone.
    assign r_take = rvalid && rready;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (cmd_take) begin
                    state_next = ST_SEND;
                end
            end
            ST_SEND: begin
                if (sent) begin
                    state_next = ST_RESP;
                end
            end
            ST_RESP: begin
                if (b_take || r_take) begin
                    state_next = ST_HOLD;
                end
            end
            ST_HOLD: begin
                if (rsp_ready) begin
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            cmd_ready <= 1'b0;              // low through reset.
        end else begin
            state     <= state_next;
            cmd_ready <= (state_next == ST_IDLE);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // response capture
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (b_take) begin
            rsp_rdata <= '0;                // writes return no data.
            rsp_err   <= bresp[1];
        end else if (r_take) begin
            rsp_rdata <= rdata;
            rsp_err   <= rresp[1];          // SLVERR or DECERR.
        end
    end

    assign rsp_valid = (state == ST_HOLD);

endmodule

//--- hw/axil_regfile_slave.sv
`timescale 1ns/1ps

module axil_regfile_slave import axil_pkg::*, host_cmd_pkg::*; #(
    parameter int ADDR_W   = 12,
    parameter int NUM_REGS = 16
) (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   awvalid,
    output logic                   awready,
    input  logic [ADDR_W-1:0]      awaddr,
    input  logic [2:0]             awprot,

    input  logic                   wvalid,
    output logic                   wready,
    input  logic [AXIL_DATA_W-1:0] wdata,
    input  logic [AXIL_STRB_W-1:0] wstrb,

    output logic                   bvalid,
    input  logic                   bready,
    output axil_resp_t             bresp,

    input  logic                   arvalid,
    output logic                   arready,
    input  logic [ADDR_W-1:0]      araddr,
    input  logic [2:0]             arprot,

    output logic                   rvalid,
    input  logic                   rready,
    output logic [AXIL_DATA_W-1:0] rdata,
    output axil_resp_t             rresp
);

    localparam int IDX_W = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;

    logic [AXIL_DATA_W-1:0] regs [1:NUM_REGS-1];  // slot 0 is the id word.

    logic [ADDR_W-3:0] aw_word;
    logic [ADDR_W-3:0] ar_word;
    logic [IDX_W-1:0]  aw_idx;
    logic [IDX_W-1:0]  ar_idx;
    logic              aw_hit;
    logic              ar_hit;
    logic              wr_take;
    logic              rd_take;
    logic              wr_ok;

    // low two address bits select a byte and are ignored.
    assign aw_word = awaddr[ADDR_W-1:2];
    assign ar_word = araddr[ADDR_W-1:2];
    assign aw_idx  = aw_word[IDX_W-1:0];
    assign ar_idx  = ar_word[IDX_W-1:0];
    assign aw_hit  = (aw_word < NUM_REGS);
    assign ar_hit  = (ar_word < NUM_REGS);

    assign wr_take = awready && awvalid && wvalid;
    assign rd_take = arready && arvalid;
    assign wr_ok   = aw_hit && (aw_idx != IDX_W'(REG_ID_INDEX));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            awready <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            // one-cycle pulse, only with no B outstanding.
            awready <= awvalid && wvalid && !awready && !bvalid;
            if (wr_take) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    assign wready = awready;                // AW and W accepted together.

    always_ff @(posedge clk) begin
        if (wr_take) begin
            bresp <= wr_ok ? OKAY : SLVERR;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_take && wr_ok) begin
            for (int b = 0; b < AXIL_STRB_W; b++) begin
                if (wstrb[b]) begin
                    regs[aw_idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (rd_take) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_take) begin
            if (!ar_hit) begin
                rdata <= '0;                // out of range reads as zero.
                rresp <= SLVERR;
            end else if (ar_idx == IDX_W'(REG_ID_INDEX)) begin
                rdata <= REG_ID_VALUE;
                rresp <= OKAY;
            end else begin
                rdata <= regs[ar_idx];
                rresp <= OKAY;
            end
        end
    end

endmodule

//--- hw/axil_subsys_top.sv
`timescale 1ns/1ps

module axil_subsys_top import axil_pkg::*, host_cmd_pkg::*; #(
    parameter int ADDR_W   = 12,
    parameter int NUM_REGS = 16
) (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    input  cmd_kind_t              cmd_kind,
    input  logic [ADDR_W-1:0]      cmd_addr,
    input  logic [AXIL_DATA_W-1:0] cmd_wdata,
    input  logic [AXIL_STRB_W-1:0] cmd_wstrb,

    output logic                   rsp_valid,
    input  logic                   rsp_ready,
    output logic [AXIL_DATA_W-1:0] rsp_rdata,
    output logic                   rsp_err
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // internal channels
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic                   aw_load, w_load, ar_load;
    axil_aw_t               aw_load_data, ar_load_data;
    axil_w_t                w_load_data;
    logic                   aw_empty, w_empty, ar_empty;

    logic                   awvalid, awready;
    axil_aw_t               awaddr;
    logic                   wvalid, wready;
    axil_w_t                w_beat;
    logic                   arvalid, arready;
    axil_aw_t               araddr;

    logic                   bvalid, bready;
    axil_resp_t             bresp;
    logic                   rvalid, rready;
    axil_resp_t             rresp;
    logic [AXIL_DATA_W-1:0] rdata;

    axil_master_ctrl #(.ADDR_W(ADDR_W)) ctrl0 (
        .clk, .rst,
        .cmd_valid, .cmd_ready, .cmd_kind, .cmd_addr, .cmd_wdata, .cmd_wstrb,
        .rsp_valid, .rsp_ready, .rsp_rdata, .rsp_err,
        .aw_load, .aw_load_data, .aw_empty,
        .w_load, .w_load_data, .w_empty,
        .ar_load, .ar_load_data, .ar_empty,
        .bvalid, .bresp, .bready,
        .rvalid, .rresp, .rdata, .rready
    );

    axil_chan_reg #(.payload_t(axil_aw_t)) aw_reg0 (
        .clk, .rst,
        .load_valid(aw_load), .load_data(aw_load_data), .empty(aw_empty),
        .out_valid(awvalid), .out_data(awaddr), .out_ready(awready)
    );

    axil_chan_reg #(.payload_t(axil_w_t)) w_reg0 (
        .clk, .rst,
        .load_valid(w_load), .load_data(w_load_data), .empty(w_empty),
        .out_valid(wvalid), .out_data(w_beat), .out_ready(wready)
    );

    axil_chan_reg #(.payload_t(axil_aw_t)) ar_reg0 (
        .clk, .rst,
        .load_valid(ar_load), .load_data(ar_load_data), .empty(ar_empty),
        .out_valid(arvalid), .out_data(araddr), .out_ready(arready)
    );

    axil_regfile_slave #(.ADDR_W(ADDR_W), .NUM_REGS(NUM_REGS)) slave0 (
        .clk, .rst,
        .awvalid, .awready, .awaddr(awaddr[ADDR_W-1:0]), .awprot(AXIL_PROT_DEFAULT),
        .wvalid, .wready, .wdata(w_beat.data), .wstrb(w_beat.strb),
        .bvalid, .bready, .bresp,
        .arvalid, .arready, .araddr(araddr[ADDR_W-1:0]), .arprot(AXIL_PROT_DEFAULT),
        .rvalid, .rready, .rdata, .rresp
    );

endmodule

//--- sim/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
    parameter real PERIOD_NS  = 10.0,
    parameter int  RST_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;                        // released just after the last reset edge.
    end

endmodule

//--- sim/axil_subsys_assertions.sv
`timescale 1ns/1ps

module axil_subsys_assertions import axil_pkg::*; (
    input logic     clk,
    input logic     rst,
    input logic     awvalid,
    input logic     awready,
    input axil_aw_t awaddr,
    input logic     wvalid,
    input logic     wready,
    input axil_w_t  w_beat,
    input logic     arvalid,
    input logic     arready,
    input axil_aw_t araddr,
    input logic     bvalid,
    input logic     bready,
    input logic     rvalid,
    input logic     rready,
    input logic     cmd_ready,
    input logic     rsp_valid
);

    int unsigned aw_fails = 0;
    int unsigned w_fails  = 0;
    int unsigned ar_fails = 0;
    int unsigned b_fails  = 0;
    int unsigned r_fails  = 0;
    int unsigned cr_fails = 0;
    int unsigned fail_count;

    assign fail_count = aw_fails + w_fails + ar_fails + b_fails + r_fails + cr_fails;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // outgoing channels hold until ready
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else begin
            aw_fails++;
            $error("awvalid dropped or awaddr changed before awready");
        end

    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(w_beat))
        else begin
            w_fails++;
            $error("wvalid dropped or write beat changed before wready");
        end

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin
            ar_fails++;
            $error("arvalid dropped or araddr changed before arready");
        end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // responses and host port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    b_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else begin
            b_fails++;
            $error("bvalid dropped before bready");
        end

    r_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid)
        else begin
            r_fails++;
            $error("rvalid dropped before rready");
        end

    cmd_vs_rsp: assert property (@(posedge clk) disable iff (rst)
        !(cmd_ready && rsp_valid))
        else begin
            cr_fails++;
            $error("cmd_ready high while rsp_valid is high");
        end

endmodule

bind axil_subsys_top axil_subsys_assertions asrt0 (
    .clk, .rst,
    .awvalid, .awready, .awaddr,
    .wvalid, .wready, .w_beat,
    .arvalid, .arready, .araddr,
    .bvalid, .bready, .rvalid, .rready,
    .cmd_ready, .rsp_valid
);

//--- sim/axil_subsys_tb.sv
`timescale 1ns/1ps

module axil_subsys_tb import axil_pkg::*, host_cmd_pkg::*;;

    localparam int ADDR_W     = 12;
    localparam int NUM_REGS   = 16;
    localparam int WORDS      = 1 << (ADDR_W - 2);
    localparam int N_CMDS     = 400;
    localparam int MAX_CYCLES = N_CMDS * 40;

    logic                   clk;
    logic                   rst;
    logic                   cmd_valid;
    logic                   cmd_ready;
    cmd_kind_t              cmd_kind;
    logic [ADDR_W-1:0]      cmd_addr;
    logic [AXIL_DATA_W-1:0] cmd_wdata;
    logic [AXIL_STRB_W-1:0] cmd_wstrb;
    logic                   rsp_valid;
    logic                   rsp_ready;
    logic [AXIL_DATA_W-1:0] rsp_rdata;
    logic                   rsp_err;

    logic [AXIL_DATA_W-1:0] model [NUM_REGS];   // slot 0 unused, id word is fixed.
    logic [AXIL_DATA_W:0]   exp_q [$];          // {err, rdata} per command.
    string                  name_q [$];

    int sent         = 0;
    int received     = 0;
    int data_errors  = 0;
    int err_errors   = 0;
    int proto_errors = 0;
    int cycles       = 0;

    tb_clkgen clkgen0 (.clk, .rst);

    axil_subsys_top #(.ADDR_W(ADDR_W), .NUM_REGS(NUM_REGS)) dut0 (
        .clk, .rst,
        .cmd_valid, .cmd_ready, .cmd_kind, .cmd_addr, .cmd_wdata, .cmd_wstrb,
        .rsp_valid, .rsp_ready, .rsp_rdata, .rsp_err
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [AXIL_DATA_W:0] predict(input cmd_kind_t kind,
                                                     input logic [ADDR_W-1:0] addr,
                                                     input logic [31:0] data,
                                                     input logic [3:0] strb);
        int unsigned word;
        logic [31:0] merged;
        word = 32'(addr[ADDR_W-1:2]);
        if (word >= NUM_REGS) begin
            return {1'b1, 32'h0};           // beyond the last register.
        end
        if (kind == CMD_READ) begin
            return (word == 0) ? {1'b0, REG_ID_VALUE} : {1'b0, model[word]};
        end
        if (word == 0) begin
            return {1'b1, 32'h0};           // id word is read-only.
        end
        merged = model[word];
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = data[8*b +: 8];
            end
        end
        model[word] = merged;
        return {1'b0, 32'h0};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic send_cmd(input cmd_kind_t kind, input int unsigned word,
                            input logic [31:0] data, input logic [3:0] strb,
                            input string name);
        @(negedge clk);
        cmd_valid = 1'b1;
        cmd_kind  = kind;
        cmd_addr  = ADDR_W'(word * 4 + ($urandom % 4));   // byte offset is ignored.
        cmd_wdata = data;
        cmd_wstrb = strb;
        while (!cmd_ready) @(negedge clk);
        if (rsp_valid) begin
            proto_errors++;
            $display("%s: command accepted while a response was still pending", name);
        end
        @(posedge clk);                     // handshake edge.
        exp_q.push_back(predict(kind, cmd_addr, data, strb));
        name_q.push_back($sformatf("%s #%0d", name, sent));
        sent++;
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    initial begin : stimulus
        cmd_kind_t   kind;
        int unsigned word;
        logic [3:0]  strb;
        cmd_valid = 1'b0;
        cmd_kind  = CMD_READ;
        cmd_addr  = '0;
        cmd_wdata = '0;
        cmd_wstrb = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model[i] = '0;
        end
        void'($urandom(32'hbe11_30cf));
        while (rst) @(negedge clk);

        for (int k = 0; k < NUM_REGS; k++) begin
            send_cmd(CMD_READ, k, 32'h0, 4'h0, "reset_read");
        end
        send_cmd(CMD_WRITE, 0, 32'hdead_beef, 4'hf, "id_write");
        send_cmd(CMD_READ, 0, 32'h0, 4'h0, "id_read");
        send_cmd(CMD_WRITE, 5, 32'h1234_5678, 4'hf, "full_write");
        send_cmd(CMD_READ, 5, 32'h0, 4'h0, "full_read");
        send_cmd(CMD_WRITE, 5, 32'hcafe_f00d, 4'b0101, "partial_write");
        send_cmd(CMD_READ, 5, 32'h0, 4'h0, "partial_read");
        send_cmd(CMD_WRITE, NUM_REGS, 32'h5555_aaaa, 4'hf, "range_write");
        send_cmd(CMD_READ, NUM_REGS + 3, 32'h0, 4'h0, "range_read");

        while (sent < N_CMDS) begin
            kind = ($urandom % 2 == 0) ? CMD_READ : CMD_WRITE;
            if ($urandom % 8 == 0) begin
                word = NUM_REGS + $urandom % (WORDS - NUM_REGS);
            end else begin
                word = $urandom % NUM_REGS;
            end
            strb = ($urandom % 2 == 0) ? 4'hf : 4'($urandom);
            send_cmd(kind, word, $urandom, strb, "random_rw");
        end

        while (received < N_CMDS) @(posedge clk);
        repeat (10) @(posedge clk);         // any stray response shows up here.
        $display("errors: rdata %0d, rsp_err %0d, protocol %0d, assertion %0d",
                 data_errors, err_errors, proto_errors, dut0.asrt0.fail_count);
        if (data_errors + err_errors + proto_errors + int'(dut0.asrt0.fail_count) == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // response side and comparison
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin : response_check
        logic [AXIL_DATA_W:0] exp;
        string                name;
        rsp_ready = 1'b0;
        forever begin
            @(negedge clk);
            rsp_ready = ($urandom % 4) != 0;    // low about one cycle in four.
            if (!rst) begin
                if (rsp_valid !== 1'b0 && rsp_valid !== 1'b1) begin
                    proto_errors++;
                    $display("rsp_valid is unknown after reset");
                end else if (rsp_valid && exp_q.size() == 0) begin
                    proto_errors++;
                    $display("rsp_valid is high with no command outstanding");
                end else if (rsp_valid) begin
                    exp  = exp_q[0];
                    name = name_q[0];
                    if (rsp_rdata !== exp[31:0]) begin
                        data_errors++;
                        $display("error %s: rsp_rdata expected %h actual %h",
                                 name, exp[31:0], rsp_rdata);
                    end
                    if (rsp_err !== exp[32]) begin
                        err_errors++;
                        $display("error %s: rsp_err expected %b actual %b",
                                 name, exp[32], rsp_err);
                    end
                    if (rsp_ready) begin
                        void'(exp_q.pop_front());
                        void'(name_q.pop_front());
                        received++;
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

endmodule

//--- vlog.f
hw/axil_pkg.sv
hw/host_cmd_pkg.sv
hw/axil_chan_reg.sv
hw/axil_master_ctrl.sv
hw/axil_regfile_slave.sv
hw/axil_subsys_top.sv
sim/tb_clkgen.sv
sim/axil_subsys_assertions.sv
sim/axil_subsys_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= axil_subsys_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SEED      ?= 1
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) +verilator+seed+$(SEED) +verilator+error+limit+1000 \
		> $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
